//--- hdl/rv32i_pkg.sv
package rv32i_pkg;

  // Data and address word
  typedef logic [31:0] word_t;
  // Register index
  typedef logic [4:0]  reg_addr_t;

  // Major opcodes, instr[6:0]
  typedef enum logic [6:0] {
    LUI     = 7'b0110111,
    AUIPC   = 7'b0010111,
    JAL     = 7'b1101111,
    JALR    = 7'b1100111,
    BRANCH  = 7'b1100011,
    LOAD    = 7'b0000011,
    STORE   = 7'b0100011,
    IMMED   = 7'b0010011,
    REGREG  = 7'b0110011,
    HALT_OP = 7'b1111111
  } opcode_t;

  // Load funct3, stores use the LB/LH/LW codes
  typedef enum logic [2:0] {
    LB  = 3'b000,
    LH  = 3'b001,
    LW  = 3'b010,
    LBU = 3'b100,
    LHU = 3'b101
  } load_t;

  // Branch funct3
  typedef enum logic [2:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
  } branch_t;

  typedef enum logic [3:0] {
    ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND
  } alu_op_t;

  // Write-back source
  typedef enum logic [1:0] {
    WB_LOAD, WB_PC4, WB_IMM_U, WB_ALU
  } wb_sel_t;

  // Registered fetch to execute payload
  typedef struct packed {
    logic  valid;
    word_t instr;
    word_t pc;
    word_t pc4;
    logic  prediction;
  } fetch_ex_t;

  // Data bus request
  typedef struct packed {
    logic       ren;
    logic       wen;
    word_t      addr;
    word_t      wdata;
    logic [3:0] byte_en;
  } dbus_req_t;

  typedef struct packed {
    logic      wen;
    reg_addr_t rd;
    word_t     data;
  } wb_t;

  // Decoded controls
  typedef struct packed {
    // Port A: 0 rs1, 1 pc, 2 zero
    logic [1:0] alu_a_sel;
    // Port B: 0 rs2, 1 immediate
    logic       alu_b_sel;
    alu_op_t    alu_op;
    word_t      imm;
    logic       dren;
    logic       dwen;
    load_t      load_type;
    logic       branch;
    logic       jump;
    logic       jalr_sel;
    branch_t    branch_type;
    wb_sel_t    wb_sel;
    logic       reg_wen;
    logic       illegal;
    logic       halt;
  } ctrl_t;

endpackage

//--- hdl/control_unit.sv
`timescale 1ns/10ps

module control_unit (
  input  rv32i_pkg::word_t instr,
  output rv32i_pkg::ctrl_t ctrl
);

  logic [2:0]         funct3;
  logic [6:0]         funct7;
  rv32i_pkg::opcode_t opcode;
  rv32i_pkg::word_t   imm_i, imm_s, imm_b, imm_u, imm_j;

  // funct3 and an alternate bit pick the ALU op
  function automatic rv32i_pkg::alu_op_t alu_decode(input logic [2:0] f3, input logic alt);
    rv32i_pkg::alu_op_t op;
    case (f3)
      3'd0:    op = alt ? rv32i_pkg::SUB : rv32i_pkg::ADD;
      3'd1:    op = rv32i_pkg::SLL;
      3'd2:    op = rv32i_pkg::SLT;
      3'd3:    op = rv32i_pkg::SLTU;
      3'd4:    op = rv32i_pkg::XOR;
      3'd5:    op = alt ? rv32i_pkg::SRA : rv32i_pkg::SRL;
      3'd6:    op = rv32i_pkg::OR;
      default: op = rv32i_pkg::AND;
    endcase
    return op;
  endfunction

  assign opcode = rv32i_pkg::opcode_t'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  // Sign-extended immediates per format
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'h000};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    ctrl             = '0;
    ctrl.alu_op      = rv32i_pkg::ADD;
    ctrl.wb_sel      = rv32i_pkg::WB_ALU;
    // Same funct3 bits for loads, stores and branches
    ctrl.load_type   = rv32i_pkg::load_t'(funct3);
    ctrl.branch_type = rv32i_pkg::branch_t'(funct3);
    case (opcode)
      rv32i_pkg::LUI: begin
        ctrl.alu_a_sel = 2'd2;
        ctrl.alu_b_sel = 1'b1;
        ctrl.imm       = imm_u;
        ctrl.wb_sel    = rv32i_pkg::WB_IMM_U;
        ctrl.reg_wen   = 1'b1;
      end
      rv32i_pkg::AUIPC: begin
        ctrl.alu_a_sel = 2'd1;
        ctrl.alu_b_sel = 1'b1;
        ctrl.imm       = imm_u;
        ctrl.reg_wen   = 1'b1;
      end
      rv32i_pkg::JAL: begin
        ctrl.jump    = 1'b1;
        ctrl.imm     = imm_j;
        ctrl.wb_sel  = rv32i_pkg::WB_PC4;
        ctrl.reg_wen = 1'b1;
      end
      rv32i_pkg::JALR: begin
        ctrl.jump     = 1'b1;
        ctrl.jalr_sel = 1'b1;
        ctrl.imm      = imm_i;
        ctrl.wb_sel   = rv32i_pkg::WB_PC4;
        ctrl.reg_wen  = 1'b1;
        ctrl.illegal  = (funct3 != 3'd0);
      end
      rv32i_pkg::BRANCH: begin
        ctrl.branch  = 1'b1;
        ctrl.imm     = imm_b;
        // 2 and 3 are unassigned
        ctrl.illegal = (funct3[2:1] == 2'b01);
      end
      rv32i_pkg::LOAD: begin
        ctrl.dren      = 1'b1;
        ctrl.alu_b_sel = 1'b1;
        ctrl.imm       = imm_i;
        ctrl.wb_sel    = rv32i_pkg::WB_LOAD;
        ctrl.reg_wen   = 1'b1;
        ctrl.illegal   = (funct3 == 3'd3) || (funct3 == 3'd6) || (funct3 == 3'd7);
      end
      rv32i_pkg::STORE: begin
        ctrl.dwen      = 1'b1;
        ctrl.alu_b_sel = 1'b1;
        ctrl.imm       = imm_s;
        ctrl.illegal   = (funct3 > 3'd2);
      end
      rv32i_pkg::IMMED: begin
        ctrl.alu_b_sel = 1'b1;
        ctrl.imm       = imm_i;
        // Only the right shift has an alternate form
        ctrl.alu_op    = alu_decode(funct3, (funct3 == 3'd5) && funct7[5]);
        ctrl.reg_wen   = 1'b1;
        if (funct3 == 3'd1)
          ctrl.illegal = (funct7 != 7'd0);
        else if (funct3 == 3'd5)
          ctrl.illegal = (funct7 != 7'd0) && (funct7 != 7'b0100000);
      end
      rv32i_pkg::REGREG: begin
        ctrl.alu_op  = alu_decode(funct3, funct7[5]);
        ctrl.reg_wen = 1'b1;
        // SUB/SRA pattern only with funct3 0 or 5
        ctrl.illegal = (funct7 != 7'd0) &&
                       !((funct7 == 7'b0100000) && ((funct3 == 3'd0) || (funct3 == 3'd5)));
      end
      rv32i_pkg::HALT_OP: ctrl.halt = 1'b1;
      default:            ctrl.illegal = 1'b1;
    endcase
    // No side effects from an illegal word
    if (ctrl.illegal) begin
      ctrl.reg_wen = 1'b0;
      ctrl.dren    = 1'b0;
      ctrl.dwen    = 1'b0;
    end
  end

endmodule

//--- hdl/rv32i_reg_file.sv
`timescale 1ns/10ps

module rv32i_reg_file (
  input  logic                CLK,
  input  logic                rst_n,
  input  rv32i_pkg::reg_addr_t rs1,
  input  rv32i_pkg::reg_addr_t rs2,
  output rv32i_pkg::word_t    rs1_data,
  output rv32i_pkg::word_t    rs2_data,
  input  rv32i_pkg::wb_t      wb
);

  rv32i_pkg::word_t regs [32];

  // Single write port, x0 never written
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      regs <= '{default: '0};
    end else if (wb.wen && (wb.rd != 5'd0)) begin
      regs[wb.rd] <= wb.data;
    end
  end

  // Asynchronous reads
  assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

//--- hdl/alu.sv
`timescale 1ns/10ps

module alu (
  input  rv32i_pkg::alu_op_t alu_op,
  input  rv32i_pkg::word_t   port_a,
  input  rv32i_pkg::word_t   port_b,
  output rv32i_pkg::word_t   result
);

  logic [4:0] shamt;

  // Shift amount from the low five bits
  assign shamt = port_b[4:0];

  always_comb begin
    case (alu_op)
      rv32i_pkg::ADD:  result = port_a + port_b;
      rv32i_pkg::SUB:  result = port_a - port_b;
      rv32i_pkg::SLL:  result = port_a << shamt;
      // Signed compare
      rv32i_pkg::SLT:  result = {31'd0, $signed(port_a) < $signed(port_b)};
      rv32i_pkg::SLTU: result = {31'd0, port_a < port_b};
      rv32i_pkg::XOR:  result = port_a ^ port_b;
      rv32i_pkg::SRL:  result = port_a >> shamt;
      // Arithmetic shift keeps the sign
      rv32i_pkg::SRA:  result = $signed(port_a) >>> shamt;
      rv32i_pkg::OR:   result = port_a | port_b;
      rv32i_pkg::AND:  result = port_a & port_b;
      default:         result = '0;
    endcase
  end

endmodule

//--- hdl/branch_jump_unit.sv
`timescale 1ns/10ps

module branch_jump_unit (
  input  rv32i_pkg::word_t   rs1_data,
  input  rv32i_pkg::word_t   rs2_data,
  input  rv32i_pkg::word_t   pc,
  input  rv32i_pkg::word_t   pc4,
  input  rv32i_pkg::word_t   imm,
  input  logic               branch,
  input  logic               jump,
  input  logic               jalr_sel,
  input  logic               prediction,
  input  rv32i_pkg::branch_t branch_type,
  output rv32i_pkg::word_t   brj_addr,
  output logic               mispredict
);

  logic             taken;
  rv32i_pkg::word_t pc_target;
  rv32i_pkg::word_t jalr_target;

  // Branch and jal share the pc-relative adder
  assign pc_target   = pc + imm;
  // jalr drops bit 0
  assign jalr_target = (rs1_data + imm) & ~32'd1;

  always_comb begin
    case (branch_type)
      rv32i_pkg::BEQ:  taken = (rs1_data == rs2_data);
      rv32i_pkg::BNE:  taken = (rs1_data != rs2_data);
      rv32i_pkg::BLT:  taken = ($signed(rs1_data) < $signed(rs2_data));
      rv32i_pkg::BGE:  taken = ($signed(rs1_data) >= $signed(rs2_data));
      rv32i_pkg::BLTU: taken = (rs1_data < rs2_data);
      rv32i_pkg::BGEU: taken = (rs1_data >= rs2_data);
      default:         taken = 1'b0;
    endcase
  end

  always_comb begin
    if (jump) begin
      brj_addr   = jalr_sel ? jalr_target : pc_target;
      // Fetch predicted fall-through if prediction is low
      mispredict = ~prediction;
    end else if (branch) begin
      brj_addr   = taken ? pc_target : pc4;
      mispredict = prediction ^ taken;
    end else begin
      brj_addr   = pc4;
      mispredict = 1'b0;
    end
  end

endmodule

//--- hdl/mem_access.sv
`timescale 1ns/10ps

module mem_access #(
  parameter bit big_endian_bus = 1'b0
) (
  input  rv32i_pkg::word_t     addr,
  input  rv32i_pkg::word_t     store_data,
  input  rv32i_pkg::word_t     drdata,
  input  rv32i_pkg::load_t     load_type,
  input  logic                 dren,
  input  logic                 dwen,
  input  logic                 stall,
  input  logic                 valid,
  output rv32i_pkg::dbus_req_t dbus,
  output rv32i_pkg::word_t     load_data,
  output logic                 mal_l,
  output logic                 mal_s
);

  logic [1:0]       offset;
  logic [3:0]       byte_en_le;
  logic             misaligned;
  rv32i_pkg::word_t wdata_le;
  rv32i_pkg::word_t rdata_le;
  rv32i_pkg::word_t lane;

  // Reverse byte order of a word
  function automatic rv32i_pkg::word_t mirror(input rv32i_pkg::word_t w);
    return {w[7:0], w[15:8], w[23:16], w[31:24]};
  endfunction

  assign offset = addr[1:0];

  // Enables and width checks, little-endian lane order
  always_comb begin
    case (load_type)
      rv32i_pkg::LB, rv32i_pkg::LBU: begin
        byte_en_le = 4'b0001 << offset;
        misaligned = 1'b0;
      end
      rv32i_pkg::LH, rv32i_pkg::LHU: begin
        byte_en_le = offset[1] ? 4'b1100 : 4'b0011;
        misaligned = offset[0];
      end
      default: begin
        byte_en_le = 4'b1111;
        misaligned = (offset != 2'b00);
      end
    endcase
  end

  // Store data replicated across lanes
  always_comb begin
    case (load_type)
      rv32i_pkg::LB: wdata_le = {4{store_data[7:0]}};
      rv32i_pkg::LH: wdata_le = {2{store_data[15:0]}};
      default:       wdata_le = store_data;
    endcase
  end

  assign mal_l = valid & dren & misaligned;
  assign mal_s = valid & dwen & misaligned;

  // Strobes only for a live aligned access
  assign dbus.ren     = valid & ~stall & dren & ~misaligned;
  assign dbus.wen     = valid & ~stall & dwen & ~misaligned;
  assign dbus.addr    = addr;
  assign dbus.byte_en = big_endian_bus ? {byte_en_le[0], byte_en_le[1],
                                          byte_en_le[2], byte_en_le[3]} : byte_en_le;
  assign dbus.wdata   = big_endian_bus ? mirror(wdata_le) : wdata_le;

  // Read lanes back to little-endian, then shift the addressed lane down
  assign rdata_le = big_endian_bus ? mirror(drdata) : drdata;
  assign lane     = rdata_le >> {offset, 3'b000};

  always_comb begin
    case (load_type)
      rv32i_pkg::LB:  load_data = {{24{lane[7]}}, lane[7:0]};
      rv32i_pkg::LBU: load_data = {24'd0, lane[7:0]};
      rv32i_pkg::LH:  load_data = {{16{lane[15]}}, lane[15:0]};
      rv32i_pkg::LHU: load_data = {16'd0, lane[15:0]};
      default:        load_data = rdata_le;
    endcase
  end

endmodule

//--- hdl/execute_stage.sv
`timescale 1ns/10ps

module execute_stage #(
  parameter bit big_endian_bus = 1'b0
) (
  input  logic                 CLK,
  input  logic                 rst_n,
  input  rv32i_pkg::fetch_ex_t fetch_ex,
  input  logic                 stall,
  input  logic                 dbusy,
  input  rv32i_pkg::word_t     drdata,
  output rv32i_pkg::dbus_req_t dbus,
  output rv32i_pkg::wb_t       wb,
  output rv32i_pkg::word_t     brj_addr,
  output logic                 mispredict,
  output logic                 mal_l,
  output logic                 mal_s,
  output logic                 illegal_insn,
  output logic                 halt
);

  rv32i_pkg::ctrl_t ctrl;
  rv32i_pkg::word_t rs1_data, rs2_data;
  rv32i_pkg::word_t port_a, port_b;
  rv32i_pkg::word_t alu_result;
  rv32i_pkg::word_t load_data;
  logic             brj_mispredict;

  control_unit u_control_unit (
    .instr (fetch_ex.instr),
    .ctrl  (ctrl)
  );

  // Register indices straight from the instruction
  rv32i_reg_file u_rv32i_reg_file (
    .CLK      (CLK),
    .rst_n    (rst_n),
    .rs1      (fetch_ex.instr[19:15]),
    .rs2      (fetch_ex.instr[24:20]),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wb       (wb)
  );

  // Operand selects
  always_comb begin
    case (ctrl.alu_a_sel)
      2'd0:    port_a = rs1_data;
      2'd1:    port_a = fetch_ex.pc;
      default: port_a = '0;
    endcase
  end

  assign port_b = ctrl.alu_b_sel ? ctrl.imm : rs2_data;

  alu u_alu (
    .alu_op (ctrl.alu_op),
    .port_a (port_a),
    .port_b (port_b),
    .result (alu_result)
  );

  branch_jump_unit u_branch_jump_unit (
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .pc          (fetch_ex.pc),
    .pc4         (fetch_ex.pc4),
    .imm         (ctrl.imm),
    .branch      (ctrl.branch),
    .jump        (ctrl.jump),
    .jalr_sel    (ctrl.jalr_sel),
    .prediction  (fetch_ex.prediction),
    .branch_type (ctrl.branch_type),
    .brj_addr    (brj_addr),
    .mispredict  (brj_mispredict)
  );

  // ALU result is the data address
  mem_access #(
    .big_endian_bus (big_endian_bus)
  ) u_mem_access (
    .addr       (alu_result),
    .store_data (rs2_data),
    .drdata     (drdata),
    .load_type  (ctrl.load_type),
    .dren       (ctrl.dren),
    .dwen       (ctrl.dwen),
    .stall      (stall),
    .valid      (fetch_ex.valid),
    .dbus       (dbus),
    .load_data  (load_data),
    .mal_l      (mal_l),
    .mal_s      (mal_s)
  );

  // Write-back source
  always_comb begin
    case (ctrl.wb_sel)
      rv32i_pkg::WB_LOAD:  wb.data = load_data;
      rv32i_pkg::WB_PC4:   wb.data = fetch_ex.pc4;
      rv32i_pkg::WB_IMM_U: wb.data = ctrl.imm;
      default:             wb.data = alu_result;
    endcase
  end

  assign wb.rd  = fetch_ex.instr[11:7];
  // Hold the write while stalled, the bus is busy or a load is misaligned
  assign wb.wen = ctrl.reg_wen & fetch_ex.valid & ~stall & ~dbusy & ~mal_l;

  // No redirect while the stage is held
  assign mispredict   = brj_mispredict & fetch_ex.valid & ~stall;
  assign illegal_insn = ctrl.illegal & fetch_ex.valid;
  assign halt         = ctrl.halt & fetch_ex.valid;

endmodule

//--- test/tb_execute_stage.sv
`timescale 1ns/10ps

module tb_execute_stage #(
  parameter int seed           = 12601,
  parameter bit big_endian_bus = 1'b0
);

  logic                 CLK;
  logic                 rst_n;
  rv32i_pkg::fetch_ex_t fetch_ex;
  logic                 stall;
  logic                 dbusy;
  rv32i_pkg::word_t     drdata;
  rv32i_pkg::dbus_req_t dbus;
  rv32i_pkg::wb_t       wb;
  rv32i_pkg::word_t     brj_addr;
  logic mispredict, mal_l, mal_s, illegal_insn, halt;

  // Reference state
  logic [31:0] regs [32];
  logic [31:0] mem [256];
  logic [31:0] pc;

  // Expected values for the current cycle
  logic [31:0] e_data, e_next, e_addr, e_wdata, e_drdata;
  logic [3:0]  e_be;
  logic [4:0]  e_rd;
  logic        e_wb_wen, e_ren, e_wen, e_misp, e_mal_l, e_mal_s, e_ill, e_halt;
  logic        e_reg, e_store;

  execute_stage #(.big_endian_bus(big_endian_bus)) u_execute_stage (
    .CLK (CLK), .rst_n (rst_n), .fetch_ex (fetch_ex), .stall (stall),
    .dbusy (dbusy), .drdata (drdata), .dbus (dbus), .wb (wb),
    .brj_addr (brj_addr), .mispredict (mispredict), .mal_l (mal_l),
    .mal_s (mal_s), .illegal_insn (illegal_insn), .halt (halt)
  );

  initial CLK = 1'b0;
  always #20 CLK = ~CLK;

  function automatic logic [31:0] byte_swap(input logic [31:0] w);
    return {w[7:0], w[15:8], w[23:16], w[31:24]};
  endfunction

  // RV32I integer ops by funct3 where alt selects SUB or SRA
  function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] x, input logic [31:0] y);
    case (f3)
      3'd0:    return alt ? x - y : x + y;
      3'd1:    return x << y[4:0];
      3'd2:    return {31'd0, $signed(x) < $signed(y)};
      3'd3:    return {31'd0, x < y};
      3'd4:    return x ^ y;
      3'd5:    return alt ? 32'($signed(x) >>> y[4:0]) : x >> y[4:0];
      3'd6:    return x | y;
      default: return x & y;
    endcase
  endfunction

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("MISMATCH %s got %h expected %h", name, got, exp);
      $display("=== FAIL ===");
      $fatal(1, "value check failed");
    end
  endtask

  // ISA model for one cycle of the instruction on fetch_ex
  task automatic predict(input logic [31:0] ins, input logic pred, input logic st,
                         input logic busy);
    logic [6:0]  op;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [31:0] a, b, im_i, im_s, im_b, im_j, im_u, word, sh;
    logic        ld, jmp, br, taken, mis;
    logic [1:0]  off;
    op = ins[6:0];
    f3 = ins[14:12];
    f7 = ins[31:25];
    a  = regs[ins[19:15]];
    b  = regs[ins[24:20]];
    im_i = {{20{ins[31]}}, ins[31:20]};
    im_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    im_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
    im_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
    im_u = {ins[31:12], 12'd0};
    {e_reg, e_store, ld, jmp, br, taken, e_ill, e_halt} = '0;
    e_next = pc + 4;
    e_data = '0;
    e_addr = '0;
    e_rd   = ins[11:7];
    case (op)
      7'h37: {e_reg, e_data} = {1'b1, im_u};
      7'h17: {e_reg, e_data} = {1'b1, pc + im_u};
      7'h6f: {e_reg, jmp, e_data, e_next} = {2'b11, pc + 32'd4, pc + im_j};
      7'h67: begin
        e_ill = (f3 != 3'd0);
        {e_reg, jmp, e_data, e_next} = {2'b11, pc + 32'd4, (a + im_i) & ~32'd1};
      end
      7'h63: begin
        e_ill = (f3 == 3'd2) || (f3 == 3'd3);
        br    = 1'b1;
        case (f3)
          3'd0:    taken = (a == b);
          3'd1:    taken = (a != b);
          3'd4:    taken = $signed(a) < $signed(b);
          3'd5:    taken = $signed(a) >= $signed(b);
          3'd6:    taken = a < b;
          default: taken = a >= b;
        endcase
        if (taken)
          e_next = pc + im_b;
      end
      7'h03: {e_ill, ld, e_reg, e_addr} = {f3 == 3'd3 || f3 > 3'd5, 2'b11, a + im_i};
      7'h23: {e_ill, e_store, e_addr} = {f3 > 3'd2, 1'b1, a + im_s};
      7'h13: begin
        e_reg  = 1'b1;
        e_ill  = (f3 == 3'd1 && f7 != 0) || (f3 == 3'd5 && f7 != 0 && f7 != 7'h20);
        e_data = alu_model(f3, f3 == 3'd5 && f7[5], a, im_i);
      end
      7'h33: begin
        e_reg  = 1'b1;
        e_ill  = f7 != 0 && !(f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
        e_data = alu_model(f3, f7[5], a, b);
      end
      7'h7f:   e_halt = 1'b1;
      default: e_ill = 1'b1;
    endcase
    // Width rules over the address offset
    off = e_addr[1:0];
    mis = (f3[1:0] == 2'd2 && off != 0) || (f3[1:0] == 2'd1 && off[0]);
    case (f3[1:0])
      2'd0:    {e_be, e_wdata} = {4'b0001 << off, {4{b[7:0]}}};
      2'd1:    {e_be, e_wdata} = {4'b0011 << off, {2{b[15:0]}}};
      default: {e_be, e_wdata} = {4'b1111, b};
    endcase
    word = mem[e_addr[9:2]];
    sh   = word >> {off, 3'b000};
    if (ld) begin
      case (f3)
        3'd0:    e_data = {{24{sh[7]}}, sh[7:0]};
        3'd1:    e_data = {{16{sh[15]}}, sh[15:0]};
        3'd4:    e_data = {24'd0, sh[7:0]};
        3'd5:    e_data = {16'd0, sh[15:0]};
        default: e_data = word;
      endcase
    end
    // Illegal words have no side effects
    e_mal_l  = ld && mis && !e_ill;
    e_mal_s  = e_store && mis && !e_ill;
    e_ren    = ld && !mis && !e_ill && !st;
    e_wen    = e_store && !mis && !e_ill && !st;
    e_wb_wen = e_reg && !e_ill && !st && !busy && !e_mal_l;
    e_misp   = !st && (jmp ? !pred : (br ? pred ^ taken : 1'b0));
    e_drdata = big_endian_bus ? byte_swap(word) : word;
    if (big_endian_bus) begin
      e_be    = {e_be[0], e_be[1], e_be[2], e_be[3]};
      e_wdata = byte_swap(e_wdata);
    end
  endtask

  task automatic check_outputs(input logic is_valid);
    if (!is_valid) begin
      {e_ren, e_wen, e_wb_wen, e_misp, e_mal_l, e_mal_s, e_ill, e_halt} = '0;
    end else begin
      check_val("brj_addr", brj_addr, e_next);
      if (e_wb_wen) begin
        check_val("wb.rd", 32'(wb.rd), 32'(e_rd));
        check_val("wb.data", wb.data, e_data);
      end
      if (e_ren || e_wen)
        check_val("dbus.addr", dbus.addr, e_addr);
      if (e_wen) begin
        check_val("dbus.byte_en", 32'(dbus.byte_en), 32'(e_be));
        check_val("dbus.wdata", dbus.wdata, e_wdata);
      end
    end
    check_val("dbus.ren", 32'(dbus.ren), 32'(e_ren));
    check_val("dbus.wen", 32'(dbus.wen), 32'(e_wen));
    check_val("wb.wen", 32'(wb.wen), 32'(e_wb_wen));
    check_val("mispredict", 32'(mispredict), 32'(e_misp));
    check_val("mal_l", 32'(mal_l), 32'(e_mal_l));
    check_val("mal_s", 32'(mal_s), 32'(e_mal_s));
    check_val("illegal_insn", 32'(illegal_insn), 32'(e_ill));
    check_val("halt", 32'(halt), 32'(e_halt));
  endtask

  // Runs one instruction and holds it through stall and dbusy until it retires
  task automatic run_instr(input logic [31:0] ins);
    int   busy_left;
    int   cycles;
    logic pred;
    logic done;
    pred = 1'($urandom % 2);
    busy_left = (ins[6:0] == 7'h03 || ins[6:0] == 7'h23) ? $urandom % 4 : 0;
    done   = 1'b0;
    cycles = 0;
    while (!done) begin
      @(negedge CLK);
      fetch_ex = '{valid: 1'b1, instr: ins, pc: pc, pc4: pc + 4, prediction: pred};
      stall = ($urandom % 8 == 0);
      dbusy = (busy_left > 0);
      predict(ins, pred, stall, dbusy);
      // Busy only ever covers a real bus access
      if (!(e_ren || e_wen || stall))
        dbusy = 1'b0;
      predict(ins, pred, stall, dbusy);
      drdata = e_drdata;
      #15;
      check_outputs(1'b1);
      if (!stall && !dbusy) begin
        if (e_wb_wen && ins[11:7] != 5'd0)
          regs[ins[11:7]] = e_data;
        for (int i = 0; i < 4; i++)
          if (e_wen && (big_endian_bus ? e_be[3 - i] : e_be[i]))
            mem[e_addr[9:2]][8*i +: 8] =
              8'((big_endian_bus ? byte_swap(e_wdata) : e_wdata) >> 8*i);
        pc   = e_next;
        done = 1'b1;
      end else if (dbusy) begin
        busy_left--;
      end
      cycles++;
      if (cycles > 40) begin
        $display("=== FAIL ===");
        $fatal(1, "instruction did not retire, stall or dbusy never released");
      end
    end
  endtask

  function automatic logic [31:0] random_instr();
    logic [31:0] r;
    logic [11:0] imm;
    logic [2:0]  f3;
    int          k;
    int          p;
    r = $urandom;
    k = $urandom % 100;
    p = $urandom % 5;
    if (k < 15) begin
      r[31:25] = ($urandom % 2) ? 7'h20 : 7'h00;
      return {r[31:7], 7'h33};
    end else if (k < 30) begin
      if (r[13:12] == 2'b01) r[31:25] = ($urandom % 2) ? 7'h20 : 7'h00;
      return {r[31:7], 7'h13};
    end
    if (k < 36) return {r[31:7], 7'h37};
    if (k < 42) return {r[31:7], 7'h17};
    if (k < 48) return {r[31:7], 7'h6f};
    if (k < 54) return {r[31:15], 3'd0, r[11:7], 7'h67};
    if (k < 66) begin
      f3 = 3'($urandom % 6);
      return {r[31:15], (f3 < 2) ? f3 : f3 + 3'd2, r[11:7], 7'h63};
    end
    if (k < 90) begin
      // Aligned word offsets from x0 with a few nudged off alignment
      f3  = (k < 78) ? ((p < 3) ? 3'(p) : 3'(p + 1)) : 3'($urandom % 3);
      imm = 12'(($urandom % 256) * 4);
      if (f3[1:0] == 2'd0) imm[1:0] = 2'($urandom);
      else if (f3[1:0] == 2'd1) imm[1] = 1'($urandom % 2);
      if ($urandom % 16 == 0) imm[1:0] = 2'(1 + $urandom % 3);
      if (k < 78) return {imm, 5'd0, f3, r[11:7], 7'h03};
      return {imm[11:5], r[24:20], 5'd0, f3, imm[4:0], 7'h23};
    end
    if (k < 96) return {r[31:7], 7'h0b};
    if (k < 98) return 32'hffff_ffff;
    return {r[31:15], 3'd3, r[11:7], 7'h03};
  endfunction

  initial begin
    void'($urandom(seed));
    rst_n    = 1'b0;
    fetch_ex = '0;
    stall    = 1'b0;
    dbusy    = 1'b0;
    drdata   = '0;
    pc       = 32'h0000_1000;
    for (int i = 0; i < 32; i++)
      regs[i] = '0;
    // Fill depends on every address bit
    for (int i = 0; i < 256; i++)
      mem[i] = {8'(i), 8'(~i), 8'(i * 7), 8'(i ^ 8'h5a)};
    repeat (8) @(posedge CLK);
    @(negedge CLK);
    rst_n = 1'b1;
    // Quiet outputs with valid low straight out of reset
    #15;
    check_outputs(1'b0);
    // ADD xr, x0, xr shows each register cleared
    for (int r = 1; r < 32; r++)
      run_instr({7'h00, 5'(r), 5'd0, 3'd0, 5'(r), 7'h33});
    for (int n = 0; n < 2000; n++) begin
      if ($urandom % 10 == 0) begin
        @(negedge CLK);
        fetch_ex = '{valid: 1'b0, instr: $urandom, pc: pc, pc4: pc + 4, prediction: 1'b1};
        stall = 1'($urandom % 2);
        dbusy = 1'b0;
        #15;
        check_outputs(1'b0);
      end
      run_instr(random_instr());
    end
    $display("=== PASS ===");
    $finish;
  end

endmodule

//--- src.f
hdl/rv32i_pkg.sv
hdl/control_unit.sv
hdl/rv32i_reg_file.sv
hdl/alu.sv
hdl/branch_jump_unit.sv
hdl/mem_access.sv
hdl/execute_stage.sv
test/tb_execute_stage.sv

//--- Makefile
# Verilator flow for the execute stage
VERILATOR  ?= verilator
TOP        ?= tb_execute_stage
SEED       ?= 12601
BIG_ENDIAN ?= 0
OBJ_DIR    ?= obj_dir

VFLAGS = --timing -f src.f --top-module $(TOP) -Gseed=$(SEED) -Gbig_endian_bus=$(BIG_ENDIAN)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall $(VFLAGS)

sim:
	$(VERILATOR) --binary $(VFLAGS) --Mdir $(OBJ_DIR) -o sim_$(TOP)
	./$(OBJ_DIR)/sim_$(TOP)

clean:
	rm -rf $(OBJ_DIR)
